// File: fetch_unit.f
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/ifetch_wb.sv
rtl/inst_check.sv
rtl/fetch_unit.sv
verif/imem_wb_model.sv
verif/fetch_unit_tb.sv

// File: verif/fetch_unit_tb.sv
// testbench for the instruction fetch front end
// walks a table of words through the unit over a random latency
// Wishbone memory while a consumer model completes each instruction
`timescale 1ns/1ps
`default_nettype none

module fetch_unit_tb;

	import fetch_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_ROWS   = 28;
	localparam int MEM_WORDS  = 256;

	typedef struct packed {
		inst_t       word;
		logic        bus_err;
		logic        redirect;
		addr_t       target;
		inst_class_e cls;
		logic        illegal;
	} row_s;

	logic       clock;
	logic       reset;
	logic       wb_cyc;
	logic       wb_stb;
	addr_t      wb_adr;
	inst_t      wb_dat;
	logic       wb_ack;
	logic       wb_err;
	logic       issue_valid;
	issue_pkt_s issue_pkt;
	logic       done;
	logic       redirect;
	addr_t      redirect_pc;

	row_s       rows [0:NUM_ROWS-1];
	int         delays [0:NUM_ROWS-1];
	int         row_cnt;
	int         errors;
	int         errors_before;
	int         failed;
	addr_t      fetch_pc;
	addr_t      pc;
	inst_t      exp_inst;
	issue_pkt_s held;

	fetch_unit dut0 (
		.clock         (clock),
		.reset         (reset),
		.wb_cyc_o      (wb_cyc),
		.wb_stb_o      (wb_stb),
		.wb_adr_o      (wb_adr),
		.wb_dat_i      (wb_dat),
		.wb_ack_i      (wb_ack),
		.wb_err_i      (wb_err),
		.issue_valid_o (issue_valid),
		.issue_pkt_o   (issue_pkt),
		.done_i        (done),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc)
	);

	imem_wb_model #(.WORDS(MEM_WORDS)) imem0 (
		.clock    (clock),
		.reset    (reset),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_adr_i (wb_adr),
		.wb_dat_o (wb_dat),
		.wb_ack_o (wb_ack),
		.wb_err_o (wb_err)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	// instruction word builders, register fields are arbitrary
	function automatic inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
		input logic [6:0] opc);
		enc_i = {imm, 5'd2, f3, 5'd1, opc};
	endfunction

	function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [6:0] opc);
		enc_r = {f7, 5'd3, 5'd2, f3, 5'd1, opc};
	endfunction

	function automatic inst_t enc_s(input logic [2:0] f3, input logic [6:0] opc);
		enc_s = {7'd0, 5'd3, 5'd2, f3, 5'd4, opc};
	endfunction

	function automatic inst_t enc_u(input logic [6:0] opc);
		enc_u = {20'h12345, 5'd1, opc};
	endfunction

	// where the fetch goes after a row completes
	function automatic addr_t next_pc(input addr_t cur, input row_s row);
		next_pc = row.redirect ? {row.target[31:2], 2'b00} : cur + 32'd4;
	endfunction

	task automatic add_row(input inst_t word, input logic err, input logic redir,
		input addr_t target, input inst_class_e cls, input logic illegal);
		row_s r;
		r.word     = word;
		r.bus_err  = err;
		r.redirect = redir;
		r.target   = target;
		r.cls      = cls;
		r.illegal  = illegal;
		rows[row_cnt]   = r;
		delays[row_cnt] = $urandom_range(4, 0);
		row_cnt++;
	endtask

	task automatic load_word(input addr_t addr, input inst_t word, input logic err);
		imem0.words[(addr >> 2) % MEM_WORDS]     = word;
		imem0.err_flags[(addr >> 2) % MEM_WORDS] = err;
	endtask

	task automatic check_value(input string what, input logic [71:0] got,
		input logic [71:0] exp);
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic build_table();
		add_row(enc_u(OPC_LUI), 1'b0, 1'b0, '0, CLS_UPPER, 1'b0);
		add_row(enc_u(OPC_AUIPC), 1'b0, 1'b0, '0, CLS_UPPER, 1'b0);
		add_row(enc_i(12'h7ff, 3'b000, OPC_OPIMM), 1'b0, 1'b0, '0, CLS_ALU, 1'b0);
		add_row(enc_r(F7_ZERO, 3'b000, OPC_OP), 1'b0, 1'b0, '0, CLS_ALU, 1'b0);
		add_row(enc_r(F7_SRA, F3_SR, OPC_OPIMM), 1'b0, 1'b0, '0, CLS_ALU, 1'b0);
		add_row(enc_r(F7_ZERO, F3_SLL, OPC_OPIMM), 1'b0, 1'b0, '0, CLS_ALU, 1'b0);
		add_row(enc_i(12'h010, F3_LW, OPC_LOAD), 1'b0, 1'b0, '0, CLS_LOAD, 1'b0);
		add_row(enc_i(12'h003, F3_LBU, OPC_LOAD), 1'b0, 1'b0, '0, CLS_LOAD, 1'b0);
		add_row(enc_s(F3_SW, OPC_STORE), 1'b0, 1'b0, '0, CLS_STORE, 1'b0);
		add_row(enc_s(3'b000, OPC_BRANCH), 1'b0, 1'b0, '0, CLS_BRANCH, 1'b0);
		// taken jump, target has its low bits set
		add_row(enc_u(OPC_JAL), 1'b0, 1'b1, 32'h0000_0102, CLS_JUMP, 1'b0);
		add_row(enc_i(12'h000, 3'b000, OPC_JALR), 1'b0, 1'b0, '0, CLS_JUMP, 1'b0);
		add_row(INST_ECALL, 1'b0, 1'b0, '0, CLS_SYSTEM, 1'b0);
		add_row(INST_EBREAK, 1'b0, 1'b0, '0, CLS_SYSTEM, 1'b0);
		add_row(INST_MRET, 1'b0, 1'b0, '0, CLS_SYSTEM, 1'b0);
		// illegal forms
		add_row(enc_i(12'h000, 3'b011, OPC_LOAD), 1'b0, 1'b0, '0, CLS_NONE, 1'b1);
		add_row(enc_r(F7_SRA, F3_SLL, OPC_OPIMM), 1'b0, 1'b0, '0, CLS_NONE, 1'b1);
		add_row(enc_s(3'b011, OPC_STORE), 1'b0, 1'b0, '0, CLS_NONE, 1'b1);
		add_row(enc_i(12'h000, 3'b000, 7'b0001011), 1'b0, 1'b0, '0, CLS_NONE, 1'b1);
		add_row(32'h0ff0_000f, 1'b0, 1'b0, '0, CLS_NONE, 1'b1);
		// bus error, then a normal word that redirects back down
		add_row(enc_i(12'h001, 3'b000, OPC_OPIMM), 1'b1, 1'b0, '0, CLS_NONE, 1'b0);
		add_row(enc_i(12'h002, 3'b000, OPC_OPIMM), 1'b0, 1'b1, 32'h0000_0043, CLS_ALU, 1'b0);
		add_row(enc_i(12'h004, F3_LH, OPC_LOAD), 1'b0, 1'b0, '0, CLS_LOAD, 1'b0);
		add_row(enc_s(F3_SH, OPC_STORE), 1'b0, 1'b0, '0, CLS_STORE, 1'b0);
		add_row(enc_r(F7_ZERO, F3_SR, OPC_OPIMM), 1'b0, 1'b0, '0, CLS_ALU, 1'b0);
		add_row(enc_i(12'h008, F3_LB, OPC_LOAD), 1'b0, 1'b0, '0, CLS_LOAD, 1'b0);
		add_row(enc_i(12'h00a, F3_LHU, OPC_LOAD), 1'b0, 1'b0, '0, CLS_LOAD, 1'b0);
		add_row(enc_s(F3_SB, OPC_STORE), 1'b0, 1'b0, '0, CLS_STORE, 1'b0);
	endtask

	// address must follow the expected pc during every request
	always @(negedge clock) begin
		if (!reset) begin
			if (wb_cyc) begin
				check_value("wb_adr", wb_adr, fetch_pc);
			end
			check_value("wb_stb", wb_stb, wb_cyc);
		end
	end

	initial begin
		#(NUM_ROWS * 16 * CLK_PERIOD * 2);
		$display("timeout: the fetch unit stopped issuing before the table was finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	initial begin
		void'($urandom(92));
		reset       = 1'b1;
		done        = 1'b0;
		redirect    = 1'b0;
		redirect_pc = '0;
		errors      = 0;
		failed      = 0;
		row_cnt     = 0;
		fetch_pc    = RESET_PC;
		build_table();
		for (int a = 0; a < MEM_WORDS; a++) begin
			load_word(a * 4, (a * 4) ^ 32'hc0de_5a5a, 1'b0);
		end
		pc = RESET_PC;
		for (int i = 0; i < row_cnt; i++) begin
			load_word(pc, rows[i].word, rows[i].bus_err);
			pc = next_pc(pc, rows[i]);
		end
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < row_cnt; i++) begin
			errors_before = errors;
			do begin
				@(negedge clock);
			end while (!issue_valid);
			exp_inst = rows[i].bus_err ? '0 : rows[i].word;
			check_value("pc", issue_pkt.pc, fetch_pc);
			check_value("inst", issue_pkt.inst, exp_inst);
			check_value("class", issue_pkt.cls, rows[i].cls);
			check_value("illegal", issue_pkt.illegal, rows[i].illegal);
			check_value("bus_err", issue_pkt.bus_err, rows[i].bus_err);
			held = issue_pkt;
			// consumer stalls, packet and bus must not move
			repeat (delays[i]) begin
				@(negedge clock);
				check_value("held packet", issue_pkt, held);
				check_value("valid while stalled", issue_valid, 1'b1);
				check_value("cyc while stalled", wb_cyc, 1'b0);
			end
			@(posedge clock);
			done        <= 1'b1;
			redirect    <= rows[i].redirect;
			redirect_pc <= rows[i].target;
			@(posedge clock);
			done        <= 1'b0;
			redirect    <= 1'b0;
			redirect_pc <= '0;
			fetch_pc = next_pc(fetch_pc, rows[i]);
			@(negedge clock);
			check_value("valid after done", issue_valid, 1'b0);
			if (errors != errors_before) begin
				failed++;
			end
			$display("test %0d pc %08h: %s", i, held.pc,
				(errors == errors_before) ? "pass" : "fail");
		end
		$display("%0d tests run, %0d failed, %0d check errors", row_cnt, failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/imem_wb_model.sv
// Wishbone classic instruction memory for the fetch testbench
// read only, 0 to 3 random wait states per access, words can be
// flagged so that the access ends with err instead of ack
`timescale 1ns/1ps
`default_nettype none

module imem_wb_model #(
	parameter int WORDS = 256
) (
	input  logic             clock,
	input  logic             reset,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	input  fetch_pkg::addr_t wb_adr_i,
	output fetch_pkg::inst_t wb_dat_o,
	output logic             wb_ack_o,
	output logic             wb_err_o
);

	import fetch_pkg::*;

	localparam int IDX_W = $clog2(WORDS);

	// loaded by the testbench before reset
	inst_t words [0:WORDS-1];
	logic  err_flags [0:WORDS-1];

	logic             busy;
	int               wait_left;
	logic [IDX_W-1:0] idx;

	assign idx = wb_adr_i[IDX_W+1:2];

	always_ff @(posedge clock) begin
		if (reset) begin
			busy      <= 1'b0;
			wait_left <= 0;
			wb_ack_o  <= 1'b0;
			wb_err_o  <= 1'b0;
			wb_dat_o  <= '0;
		end else if (wb_ack_o || wb_err_o) begin
			// master samples the answer here and drops cyc
			busy     <= 1'b0;
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end else if (wb_cyc_i && wb_stb_i) begin
			if (!busy) begin
				busy      <= 1'b1;
				wait_left <= $urandom_range(3, 0);
			end else if (wait_left != 0) begin
				wait_left <= wait_left - 1;
			end else begin
				// data goes out on err too, the master must drop it
				wb_dat_o <= words[idx];
				wb_err_o <= err_flags[idx];
				wb_ack_o <= !err_flags[idx];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/fetch_unit.sv
// instruction fetch front end
// pc register, Wishbone fetch master and predecode stage in a row,
// one instruction in flight, next fetch after the consumer is done
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
	input  logic                  clock,
	input  logic                  reset,

	// instruction bus
	output logic                  wb_cyc_o,
	output logic                  wb_stb_o,
	output fetch_pkg::addr_t      wb_adr_o,
	input  fetch_pkg::inst_t      wb_dat_i,
	input  logic                  wb_ack_i,
	input  logic                  wb_err_i,

	// decode side
	output logic                  issue_valid_o,
	output fetch_pkg::issue_pkt_s issue_pkt_o,
	input  logic                  done_i,
	input  logic                  redirect_i,
	input  fetch_pkg::addr_t      redirect_pc_i
);

	import fetch_pkg::*;

	addr_t      pc;
	logic       advance;
	logic       raw_valid;
	fetch_raw_s raw_pkt;

	pc_gen pc_gen0 (
		.clock         (clock),
		.reset         (reset),
		.advance_i     (advance),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (pc)
	);

	ifetch_wb ifetch_wb0 (
		.clock       (clock),
		.reset       (reset),
		.pc_i        (pc),
		.advance_i   (advance),
		.wb_cyc_o    (wb_cyc_o),
		.wb_stb_o    (wb_stb_o),
		.wb_adr_o    (wb_adr_o),
		.wb_dat_i    (wb_dat_i),
		.wb_ack_i    (wb_ack_i),
		.wb_err_i    (wb_err_i),
		.raw_valid_o (raw_valid),
		.raw_pkt_o   (raw_pkt)
	);

	// advance comes back from here, the only place done_i is seen
	inst_check inst_check0 (
		.clock         (clock),
		.reset         (reset),
		.raw_valid_i   (raw_valid),
		.raw_pkt_i     (raw_pkt),
		.done_i        (done_i),
		.issue_valid_o (issue_valid_o),
		.issue_pkt_o   (issue_pkt_o),
		.advance_o     (advance)
	);

endmodule

`default_nettype wire

// File: rtl/inst_check.sv
// predecode and issue stage
// sorts the fetched word into a coarse class, flags encodings outside
// the supported RV32I subset and holds the result until decode is done
`timescale 1ns/1ps
`default_nettype none

module inst_check (
	input  logic                  clock,
	input  logic                  reset,

	input  logic                  raw_valid_i,
	input  fetch_pkg::fetch_raw_s raw_pkt_i,

	// consumer handshake
	input  logic                  done_i,
	output logic                  issue_valid_o,
	output fetch_pkg::issue_pkt_s issue_pkt_o,

	// completion pulse to pc_gen and ifetch_wb
	output logic                  advance_o
);

	import fetch_pkg::*;

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;

	logic        legal;
	inst_class_e cls_dec;
	inst_class_e cls_out;
	logic        illegal_out;

	logic        valid_q;
	issue_pkt_s  pkt_q;

	assign opcode = raw_pkt_i.inst[6:0];
	assign funct3 = raw_pkt_i.inst[14:12];
	assign funct7 = raw_pkt_i.inst[31:25];

	always_comb begin
		legal   = 1'b0;
		cls_dec = CLS_NONE;
		case (opcode)
			OPC_LUI, OPC_AUIPC: begin
				legal   = 1'b1;
				cls_dec = CLS_UPPER;
			end
			OPC_JAL: begin
				legal   = 1'b1;
				cls_dec = CLS_JUMP;
			end
			OPC_JALR: begin
				legal   = (funct3 == 3'b000);
				cls_dec = CLS_JUMP;
			end
			OPC_BRANCH: begin
				legal   = 1'b1;
				cls_dec = CLS_BRANCH;
			end
			OPC_LOAD: begin
				legal   = (funct3 == F3_LB) || (funct3 == F3_LH) || (funct3 == F3_LW) ||
					(funct3 == F3_LBU) || (funct3 == F3_LHU);
				cls_dec = CLS_LOAD;
			end
			OPC_STORE: begin
				legal   = (funct3 == F3_SB) || (funct3 == F3_SH) || (funct3 == F3_SW);
				cls_dec = CLS_STORE;
			end
			OPC_OPIMM: begin
				// shift amounts share the funct7 field
				if (funct3 == F3_SLL) begin
					legal = (funct7 == F7_ZERO);
				end else if (funct3 == F3_SR) begin
					legal = (funct7 == F7_ZERO) || (funct7 == F7_SRA);
				end else begin
					legal = 1'b1;
				end
				cls_dec = CLS_ALU;
			end
			OPC_OP: begin
				legal   = 1'b1;
				cls_dec = CLS_ALU;
			end
			OPC_SYSTEM: begin
				legal   = (raw_pkt_i.inst == INST_ECALL) || (raw_pkt_i.inst == INST_EBREAK) ||
					(raw_pkt_i.inst == INST_MRET);
				cls_dec = CLS_SYSTEM;
			end
			default: begin
				legal   = 1'b0;
				cls_dec = CLS_NONE;
			end
		endcase
	end

	// a bus error carries no word, so nothing to classify
	assign illegal_out = !raw_pkt_i.bus_err && !legal;
	assign cls_out     = (raw_pkt_i.bus_err || !legal) ? CLS_NONE : cls_dec;

	assign advance_o = valid_q && done_i;

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else if (raw_valid_i) begin
			valid_q <= 1'b1;
		end else if (advance_o) begin
			valid_q <= 1'b0;
		end
	end

	// payload only loads on a new word, held otherwise
	always_ff @(posedge clock) begin
		if (raw_valid_i) begin
			pkt_q.pc      <= raw_pkt_i.pc;
			pkt_q.inst    <= raw_pkt_i.inst;
			pkt_q.cls     <= cls_out;
			pkt_q.illegal <= illegal_out;
			pkt_q.bus_err <= raw_pkt_i.bus_err;
		end
	end

	assign issue_valid_o = valid_q;
	assign issue_pkt_o   = pkt_q;

endmodule

`default_nettype wire

// File: rtl/ifetch_wb.sv
// instruction fetch bus master
// runs one Wishbone classic read per instruction at the current pc,
// captures the word or the error into a raw packet and then waits
// until the instruction completes before starting the next read
`timescale 1ns/1ps
`default_nettype none

module ifetch_wb (
	input  logic                 clock,
	input  logic                 reset,

	input  fetch_pkg::addr_t     pc_i,
	input  logic                 advance_i,

	// Wishbone classic, read only
	output logic                 wb_cyc_o,
	output logic                 wb_stb_o,
	output fetch_pkg::addr_t     wb_adr_o,
	input  fetch_pkg::inst_t     wb_dat_i,
	input  logic                 wb_ack_i,
	input  logic                 wb_err_i,

	// to predecode
	output logic                 raw_valid_o,
	output fetch_pkg::fetch_raw_s raw_pkt_o
);

	import fetch_pkg::*;

	typedef enum logic [1:0] {
		FS_REQ,
		FS_CAPTURE,
		FS_WAIT
	} fetch_state_e;

	fetch_state_e state_q;
	fetch_state_e state_next;

	logic       cyc_q;
	logic       bus_done;
	fetch_raw_s raw_q;

	// slave answered, either with data or with an error
	assign bus_done = cyc_q && (wb_ack_i || wb_err_i);

	always_comb begin
		state_next = state_q;
		case (state_q)
			FS_REQ: begin
				if (bus_done) begin
					state_next = FS_CAPTURE;
				end
			end
			FS_CAPTURE: begin
				// one cycle only, predecode takes the packet here
				state_next = FS_WAIT;
			end
			FS_WAIT: begin
				if (advance_i) begin
					state_next = FS_REQ;
				end
			end
			default: begin
				state_next = FS_REQ;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state_q <= FS_REQ;
		end else begin
			state_q <= state_next;
		end
	end

	// cyc is a flop so the bus stays idle through reset
	// and drops the cycle after ack or err
	always_ff @(posedge clock) begin
		if (reset) begin
			cyc_q <= 1'b0;
		end else begin
			cyc_q <= (state_next == FS_REQ);
		end
	end

	// data is only valid on the ack edge, so grab it there
	always_ff @(posedge clock) begin
		if (state_q == FS_REQ && bus_done) begin
			raw_q.pc <= pc_i;
			if (wb_err_i) begin
				raw_q.inst    <= '0;
				raw_q.bus_err <= 1'b1;
			end else begin
				raw_q.inst    <= wb_dat_i;
				raw_q.bus_err <= 1'b0;
			end
		end
	end

	assign wb_cyc_o = cyc_q;
	assign wb_stb_o = cyc_q;

	// pc holds until the completion edge, so the address is stable
	assign wb_adr_o = pc_i;

	assign raw_valid_o = (state_q == FS_CAPTURE);
	assign raw_pkt_o   = raw_q;

endmodule

`default_nettype wire

// File: rtl/pc_gen.sv
// fetch program counter
// starts at the reset address, steps by one word on each completed
// instruction or jumps to a redirect target taken at that point
`timescale 1ns/1ps
`default_nettype none

module pc_gen (
	input  logic            clock,
	input  logic            reset,

	// completion pulse from the predecode stage
	input  logic            advance_i,

	// branch, jump or trap target from the consumer
	input  logic            redirect_i,
	input  fetch_pkg::addr_t redirect_pc_i,

	output fetch_pkg::addr_t pc_o
);

	import fetch_pkg::*;

	addr_t pc_q;
	addr_t pc_seq;
	addr_t redirect_tgt;
	addr_t pc_next;

	// sequential successor
	assign pc_seq = pc_q + 32'd4;

	// no compressed support, targets are word aligned
	assign redirect_tgt = {redirect_pc_i[31:2], 2'b00};

	always_comb begin
		pc_next = pc_q;
		if (advance_i) begin
			if (redirect_i) begin
				pc_next = redirect_tgt;
			end else begin
				pc_next = pc_seq;
			end
		end
	end

	// pc only moves at the completion edge
	always_ff @(posedge clock) begin
		if (reset) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

`default_nettype wire

// File: rtl/fetch_pkg.sv
// fetch front end shared definitions
// address and word types, the fetch and issue packets,
// the reset address and RV32I opcode and function constants
`default_nettype none

package fetch_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] inst_t;

	// coarse class handed to decode
	typedef enum logic [2:0] {
		CLS_ALU,
		CLS_LOAD,
		CLS_STORE,
		CLS_BRANCH,
		CLS_JUMP,
		CLS_UPPER,
		CLS_SYSTEM,
		CLS_NONE
	} inst_class_e;

	// one word as it came off the bus
	typedef struct packed {
		addr_t pc;
		inst_t inst;
		logic  bus_err;
	} fetch_raw_s;

	// word plus predecode result, held for the consumer
	typedef struct packed {
		addr_t       pc;
		inst_t       inst;
		inst_class_e cls;
		logic        illegal;
		logic        bus_err;
	} issue_pkt_s;

	localparam addr_t RESET_PC = 32'h0000_0000;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;
	// stores
	localparam logic [2:0] F3_SB  = 3'b000;
	localparam logic [2:0] F3_SH  = 3'b001;
	localparam logic [2:0] F3_SW  = 3'b010;
	// shifts, SRLI and SRAI share funct3
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SR  = 3'b101;

	localparam logic [6:0] F7_ZERO = 7'b0000000;
	localparam logic [6:0] F7_SRA  = 7'b0100000;

	localparam inst_t INST_ECALL  = 32'h0000_0073;
	localparam inst_t INST_EBREAK = 32'h0010_0073;
	localparam inst_t INST_MRET   = 32'h3020_0073;

endpackage

`default_nettype wire
